/* Makefile */
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= memSubsystem.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* logic/byteRam.sv */
`timescale 1ns/1ns

module byteRam #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [AddrWidth-1:0] addr,
    input  memPkg::byte_t        wdata,
    output memPkg::byte_t        rdata
);

    localparam int Depth = 1 << AddrWidth;

    memPkg::byte_t mem [Depth];

    // read returns the old byte when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* logic/instFetch.sv */
`timescale 1ns/1ns

module instFetch #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pcSet,
    input  logic [AddrWidth-1:0] pcNew,
    output logic                 fetchEn,
    output logic [AddrWidth-1:0] fetchAddr,
    input  logic                 fetchDone,
    input  memPkg::word_t        fetchInst,
    output logic                 instValid,
    output memPkg::word_t        inst,
    output logic [AddrWidth-1:0] instPc,
    input  logic                 instReady
);

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] pcStep;
    logic                 fetchOn;
    logic                 discard;
    logic                 consume;
    logic                 launch;
    logic                 keep;

    assign consume = instValid && instReady;
    assign pcStep  = pc + AddrWidth'(memPkg::InstBytes);

    // only fetch into a slot that is empty or being emptied
    assign launch = fetchOn && !pcSet && !fetchEn && (!instValid || instReady);
    assign keep   = fetchDone && !discard && !pcSet;

    // pc only moves on accept or redirect, so it tracks the held instruction
    assign instPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            fetchOn   <= 1'b0;
            fetchEn   <= 1'b0;
            instValid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (pcSet) begin
                pc      <= pcNew;
                fetchOn <= 1'b1;
            end else if (consume) begin
                pc <= pcStep;
            end

            if (fetchDone) begin
                fetchEn <= 1'b0;
            end else if (launch) begin
                fetchEn <= 1'b1;
            end

            if (pcSet) begin
                instValid <= 1'b0;
            end else if (keep) begin
                instValid <= 1'b1;
            end else if (consume) begin
                instValid <= 1'b0;
            end

            // a redirect leaves the request in flight, its result is dropped
            if (fetchDone) begin
                discard <= 1'b0;
            end else if (pcSet && fetchEn) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fetchAddr <= instValid ? pcStep : pc;
        end
        if (keep) begin
            inst <= fetchInst;
        end
    end

endmodule

/* logic/loadStore.sv */
`timescale 1ns/1ns

module loadStore #(
    parameter int AddrWidth = 17
) (
    input  logic                      lsValid,
    input  memPkg::lsOp_e             lsOp,
    input  memPkg::funct3_t           lsFunct3,
    input  logic [AddrWidth-1:0]      lsAddr,
    input  memPkg::word_t             lsWdata,
    output logic                      lsDone,
    output memPkg::word_t             lsRdata,

    output logic                      dataEn,
    output memPkg::lsOp_e             dataOp,
    output memPkg::accessLen_e        dataLen,
    output logic [AddrWidth-1:0]      dataAddr,
    output memPkg::word_t             dataWdata,
    input  logic                      dataDone,
    input  memPkg::word_t             dataRdata
);

    logic signExt;

    // request goes straight through, only the size is decoded
    assign dataEn    = lsValid;
    assign dataOp    = lsOp;
    assign dataAddr  = lsAddr;
    assign dataWdata = lsWdata;

    // codes 3, 6 and 7 fall back to a word access
    always_comb begin
        case (lsFunct3)
            memPkg::F3Byte, memPkg::F3ByteU: dataLen = memPkg::LenOne;
            memPkg::F3Half, memPkg::F3HalfU: dataLen = memPkg::LenTwo;
            memPkg::F3Word:                  dataLen = memPkg::LenFour;
            default:                         dataLen = memPkg::LenFour;
        endcase
    end

    assign signExt = lsFunct3 == memPkg::F3Byte || lsFunct3 == memPkg::F3Half;

    assign lsDone = dataDone;

    // raw data arrives zero-extended
    always_comb begin
        case (dataLen)
            memPkg::LenOne: lsRdata = {{24{signExt && dataRdata[7]}}, dataRdata[7:0]};
            memPkg::LenTwo: lsRdata = {{16{signExt && dataRdata[15]}}, dataRdata[15:0]};
            default:        lsRdata = dataRdata;
        endcase
    end

endmodule

/* logic/memCtrl.sv */
`timescale 1ns/1ns

module memCtrl #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioFull,

    // fetch client
    input  logic                 fetchEn,
    input  logic [AddrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output memPkg::word_t        fetchInst,

    // data client
    input  logic                 dataEn,
    input  memPkg::lsOp_e        dataOp,
    input  memPkg::accessLen_e   dataLen,
    input  logic [AddrWidth-1:0] dataAddr,
    input  memPkg::word_t        dataWdata,
    output logic                 dataDone,
    output memPkg::word_t        dataRdata,

    // ram port
    output logic                 ramWe,
    output logic [AddrWidth-1:0] ramAddr,
    output memPkg::byte_t        ramWdata,
    input  memPkg::byte_t        ramRdata
);

    localparam logic [1:0] OwnIdle  = 2'd0;
    localparam logic [1:0] OwnData  = 2'd1;
    localparam logic [1:0] OwnFetch = 2'd2;

    logic [1:0]    owner;
    logic [2:0]    stage;
    memPkg::word_t gather;
    memPkg::word_t assembled;

    logic          active;
    logic          selData;
    logic          busy;
    logic          isStore;
    logic [2:0]    seqLen;
    logic [2:0]    lastStage;
    logic          finish;
    logic [2:0]    addrStage;

    // stalled cycles neither advance nor complete anything
    assign active = rdy && !ioFull;

    // data wins only at the idle grant, then the owner is locked until done
    assign selData = (owner == OwnData) || (owner == OwnIdle && dataEn);
    assign busy    = (owner != OwnIdle) || dataEn || fetchEn;
    assign isStore = selData && dataOp == memPkg::OpStore;
    assign seqLen  = selData ? dataLen : 3'(memPkg::InstBytes);

    // reads end one stage later because of the ram latency
    assign lastStage = isStore ? seqLen - 3'd1 : seqLen;
    assign finish    = active && busy && stage == lastStage;

    assign dataDone  = finish && selData;
    assign fetchDone = finish && !selData;

    // a stalled cycle re-reads the previous byte so the ram output survives the freeze
    assign addrStage = active ? stage : stage - 3'd1;

    // byte k of the access sits at base plus k
    assign ramAddr  = (selData ? dataAddr : fetchAddr) + AddrWidth'(addrStage);
    assign ramWe    = active && isStore;
    assign ramWdata = dataWdata[{stage[1:0], 3'b000} +: 8];

    // newest byte enters at the top, so the last byte lands in bits 31:24
    assign assembled = {ramRdata, gather[31:8]};
    assign fetchInst = assembled;

    always_comb begin
        case (dataLen)
            memPkg::LenOne: dataRdata = {24'd0, ramRdata};
            memPkg::LenTwo: dataRdata = {16'd0, assembled[31:16]};
            default:        dataRdata = assembled;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OwnIdle;
            stage <= '0;
        end else if (active) begin
            if (finish) begin
                owner <= OwnIdle;
                stage <= '0;
            end else if (owner == OwnIdle) begin
                if (dataEn) begin
                    owner <= OwnData;
                    stage <= 3'd1;
                end else if (fetchEn) begin
                    owner <= OwnFetch;
                    stage <= 3'd1;
                end
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            gather <= assembled;
        end
    end

endmodule

/* logic/memPkg.sv */
package memPkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // byte count of one data access
    typedef enum logic [2:0] {
        LenOne  = 3'd1,
        LenTwo  = 3'd2,
        LenFour = 3'd4
    } accessLen_e;

    typedef enum logic {
        OpLoad  = 1'b0,
        OpStore = 1'b1
    } lsOp_e;

    // risc-v width/sign field of loads and stores
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3Byte  = 3'd0;
    localparam funct3_t F3Half  = 3'd1;
    localparam funct3_t F3Word  = 3'd2;
    localparam funct3_t F3ByteU = 3'd4;
    localparam funct3_t F3HalfU = 3'd5;

    // fetch length and pc step
    localparam int InstBytes = 4;

endpackage

/* logic/memSubsystem.sv */
`timescale 1ns/1ns

module memSubsystem #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioFull,

    input  logic                 lsValid,
    input  memPkg::funct3_t      lsFunct3,
    input  memPkg::lsOp_e        lsOp,
    input  logic [AddrWidth-1:0] lsAddr,
    input  memPkg::word_t        lsWdata,
    output logic                 lsDone,
    output memPkg::word_t        lsRdata,

    input  logic                 pcSet,
    input  logic [AddrWidth-1:0] pcNew,
    output logic                 instValid,
    output memPkg::word_t        inst,
    output logic [AddrWidth-1:0] instPc,
    input  logic                 instReady
);

    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    memPkg::word_t        fetchInst;

    logic                 dataEn;
    memPkg::lsOp_e        dataOp;
    memPkg::accessLen_e   dataLen;
    logic [AddrWidth-1:0] dataAddr;
    memPkg::word_t        dataWdata;
    logic                 dataDone;
    memPkg::word_t        dataRdata;

    logic                 ramWe;
    logic [AddrWidth-1:0] ramAddr;
    memPkg::byte_t        ramWdata;
    memPkg::byte_t        ramRdata;

    byteRam #(
        .AddrWidth(AddrWidth)
    ) i_byteRam (
        .clk  (clk),
        .we   (ramWe),
        .addr (ramAddr),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) i_memCtrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .ioFull   (ioFull),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataEn   (dataEn),
        .dataOp   (dataOp),
        .dataLen  (dataLen),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataDone (dataDone),
        .dataRdata(dataRdata),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    loadStore #(
        .AddrWidth(AddrWidth)
    ) i_loadStore (
        .lsValid  (lsValid),
        .lsOp     (lsOp),
        .lsFunct3 (lsFunct3),
        .lsAddr   (lsAddr),
        .lsWdata  (lsWdata),
        .lsDone   (lsDone),
        .lsRdata  (lsRdata),
        .dataEn   (dataEn),
        .dataOp   (dataOp),
        .dataLen  (dataLen),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataDone (dataDone),
        .dataRdata(dataRdata)
    );

    instFetch #(
        .AddrWidth(AddrWidth)
    ) i_instFetch (
        .clk      (clk),
        .rst      (rst),
        .pcSet    (pcSet),
        .pcNew    (pcNew),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .instValid(instValid),
        .inst     (inst),
        .instPc   (instPc),
        .instReady(instReady)
    );

endmodule

/* memSubsystem.f */
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/instFetch.sv
logic/loadStore.sv
logic/memSubsystem.sv
testbench/memCtrl_sva.sv
testbench/memSubsystemTb.sv

/* testbench/memCtrl_sva.sv */
`timescale 1ns/1ns

module memCtrlSva (
    input logic       clk,
    input logic       rst,
    input logic       ioFull,
    input logic       dataDone,
    input logic       fetchDone,
    input logic       ramWe,
    input logic [1:0] owner
);

    // owner code of the fetch client in memCtrl
    localparam logic [1:0] OwnFetch = 2'd2;

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(dataDone && fetchDone))
        else $error("dataDone and fetchDone high in the same cycle");

    noWriteOnFetch: assert property (@(posedge clk) disable iff (rst)
        owner == OwnFetch |-> !ramWe)
        else $error("ramWe high while the fetch client owns the RAM");

    // a full io buffer freezes every completion
    noDoneWhenFull: assert property (@(posedge clk) disable iff (rst)
        ioFull |-> !(dataDone || fetchDone))
        else $error("done raised while ioFull is high");

endmodule

bind memCtrl memCtrlSva i_memCtrlSva (
    .clk      (clk),
    .rst      (rst),
    .ioFull   (ioFull),
    .dataDone (dataDone),
    .fetchDone(fetchDone),
    .ramWe    (ramWe),
    .owner    (owner)
);

/* testbench/memSubsystemTb.sv */
`timescale 1ns/1ns

module memSubsystemTb;

    localparam int AddrW = 12;
    localparam int WaitLimit = 50;

    typedef struct {
        string            name;
        memPkg::lsOp_e    op;
        memPkg::funct3_t  f3;
        logic [AddrW-1:0] addr;
        memPkg::word_t    wdata;
        memPkg::word_t    expData;
        bit               stall;
    } stimRow_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             rdy;
    logic             ioFull;
    logic             lsValid;
    memPkg::funct3_t  lsFunct3;
    memPkg::lsOp_e    lsOp;
    logic [AddrW-1:0] lsAddr;
    memPkg::word_t    lsWdata;
    logic             lsDone;
    memPkg::word_t    lsRdata;
    logic             pcSet;
    logic [AddrW-1:0] pcNew;
    logic             instValid;
    memPkg::word_t    inst;
    logic [AddrW-1:0] instPc;
    logic             instReady;

    memPkg::byte_t    shadow [1 << AddrW];
    stimRow_t         stimRows [$];
    int unsigned      lcgState = 95538;
    int               mismatchCount = 0;
    int               timeoutCount = 0;
    int               stallDoneCount = 0;

    memSubsystem #(
        .AddrWidth(AddrW)
    ) i_memSubsystem (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 16);
    endfunction

    // low two funct3 bits give the size, unknown codes act as a word
    function automatic int accessBytes(memPkg::funct3_t f3);
        return (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
    endfunction

    function automatic memPkg::word_t modelLoad(memPkg::funct3_t f3, logic [AddrW-1:0] addr);
        memPkg::word_t raw;
        raw = '0;
        for (int k = 0; k < accessBytes(f3); k++) begin
            raw[8*k +: 8] = shadow[addr + AddrW'(k)];
        end
        if (f3 == memPkg::F3Byte) begin
            raw[31:8] = {24{raw[7]}};
        end else if (f3 == memPkg::F3Half) begin
            raw[31:16] = {16{raw[15]}};
        end
        return raw;
    endfunction

    task automatic checkWord(string name, memPkg::word_t expVal, memPkg::word_t actVal);
        if (actVal !== expVal) begin
            mismatchCount++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, expVal, actVal);
        end
    endtask

    task automatic checkPc(string name, logic [AddrW-1:0] expVal, logic [AddrW-1:0] actVal);
        if (actVal !== expVal) begin
            mismatchCount++;
            $display("[ERROR] %s: expected %03h, actual %03h", name, expVal, actVal);
        end
    endtask

    task automatic addRow(string name, memPkg::lsOp_e op, memPkg::funct3_t f3,
            logic [AddrW-1:0] addr, memPkg::word_t wdata, memPkg::word_t expData, bit stall);
        stimRows.push_back(stimRow_t'{name, op, f3, addr, wdata, expData, stall});
    endtask

    task automatic runAccess(string name, memPkg::lsOp_e op, memPkg::funct3_t f3,
            logic [AddrW-1:0] addr, memPkg::word_t wdata, bit stall,
            output memPkg::word_t rdata);
        int waited;
        bit done;
        bit stallNow;
        logic [31:0] pick;
        waited = 0;
        done = 1'b0;
        rdata = '0;
        while (!done && waited < WaitLimit) begin
            @(posedge clk);
            pick = lcgNext();
            // about one cycle in four stalls, before or inside the transaction
            stallNow = stall && pick[1:0] == 2'd0;
            lsValid  <= 1'b1;
            lsOp     <= op;
            lsFunct3 <= f3;
            lsAddr   <= addr;
            lsWdata  <= wdata;
            rdy      <= !(stallNow && pick[2]);
            ioFull   <= stallNow && !pick[2];
            @(negedge clk);
            if (lsDone && (!rdy || ioFull)) begin
                stallDoneCount++;
                $display("lsDone was raised in a stalled cycle during %s", name);
            end
            done = lsDone;
            rdata = lsRdata;
            waited++;
        end
        @(posedge clk);
        lsValid <= 1'b0;
        rdy     <= 1'b1;
        ioFull  <= 1'b0;
        if (!done) begin
            timeoutCount++;
            $display("timeout: no lsDone within %0d cycles for %s", WaitLimit, name);
        end else if (op == memPkg::OpStore) begin
            for (int k = 0; k < accessBytes(f3); k++) begin
                shadow[addr + AddrW'(k)] = wdata[8*k +: 8];
            end
        end
    endtask

    task automatic redirect(logic [AddrW-1:0] pc);
        @(posedge clk);
        pcSet <= 1'b1;
        pcNew <= pc;
        @(posedge clk);
        pcSet <= 1'b0;
    endtask

    // the same instruction is expected until it is accepted
    task automatic runStream(string name, logic [AddrW-1:0] base, int count, bit randomReady);
        int idx;
        int idle;
        logic [31:0] pick;
        logic [AddrW-1:0] expPc;
        idx = 0;
        idle = 0;
        while (idx < count && idle < WaitLimit) begin
            @(posedge clk);
            pick = lcgNext();
            instReady <= !randomReady || pick[3];
            @(negedge clk);
            idle++;
            if (instValid) begin
                expPc = base + AddrW'(4 * idx);
                checkPc($sformatf("%s pc %0d", name, idx), expPc, instPc);
                checkWord($sformatf("%s inst %0d", name, idx), modelLoad(memPkg::F3Word, expPc), inst);
                if (instReady) begin
                    idx++;
                    idle = 0;
                end
            end
        end
        if (idx < count) begin
            timeoutCount++;
            $display("timeout: instruction %0d of %s never became valid", idx, name);
        end
    endtask

    initial begin
        memPkg::word_t rdata;
        logic [31:0] pick;
        rst       = 1'b1;
        rdy       = 1'b1;
        ioFull    = 1'b0;
        lsValid   = 1'b0;
        lsFunct3  = '0;
        lsOp      = memPkg::OpLoad;
        lsAddr    = '0;
        lsWdata   = '0;
        pcSet     = 1'b0;
        pcNew     = '0;
        instReady = 1'b0;

        // unaligned stores, then word loads over them
        addRow("sw 100", memPkg::OpStore, memPkg::F3Word, 12'h100, 32'h44332211, '0, 1'b0);
        addRow("sw 104", memPkg::OpStore, memPkg::F3Word, 12'h104, 32'h88776655, '0, 1'b0);
        addRow("sb 101", memPkg::OpStore, memPkg::F3Byte, 12'h101, 32'h123456a5, '0, 1'b0);
        addRow("sh 103", memPkg::OpStore, memPkg::F3Half, 12'h103, 32'hdead7f81, '0, 1'b0);
        addRow("sw 106", memPkg::OpStore, memPkg::F3Word, 12'h106, 32'hc3b21700, '0, 1'b0);
        addRow("lw 100", memPkg::OpLoad, memPkg::F3Word, 12'h100, '0, 32'h8133a511, 1'b0);
        addRow("lw 103", memPkg::OpLoad, memPkg::F3Word, 12'h103, '0, 32'h00667f81, 1'b0);
        addRow("lw 106", memPkg::OpLoad, memPkg::F3Word, 12'h106, '0, 32'hc3b21700, 1'b0);
        // sign and zero extension
        addRow("lb 101", memPkg::OpLoad, memPkg::F3Byte, 12'h101, '0, 32'hffffffa5, 1'b0);
        addRow("lbu 101", memPkg::OpLoad, memPkg::F3ByteU, 12'h101, '0, 32'h000000a5, 1'b0);
        addRow("lb 104", memPkg::OpLoad, memPkg::F3Byte, 12'h104, '0, 32'h0000007f, 1'b0);
        addRow("lbu 109", memPkg::OpLoad, memPkg::F3ByteU, 12'h109, '0, 32'h000000c3, 1'b0);
        addRow("lh 103", memPkg::OpLoad, memPkg::F3Half, 12'h103, '0, 32'h00007f81, 1'b0);
        addRow("lh 108", memPkg::OpLoad, memPkg::F3Half, 12'h108, '0, 32'hffffc3b2, 1'b0);
        addRow("lhu 108", memPkg::OpLoad, memPkg::F3HalfU, 12'h108, '0, 32'h0000c3b2, 1'b0);
        addRow("lhu 101", memPkg::OpLoad, memPkg::F3HalfU, 12'h101, '0, 32'h000033a5, 1'b0);
        // stalled transactions
        addRow("sh 10a stall", memPkg::OpStore, memPkg::F3Half, 12'h10a, 32'h0000f00d, '0, 1'b1);
        addRow("lh 10a stall", memPkg::OpLoad, memPkg::F3Half, 12'h10a, '0, 32'hfffff00d, 1'b1);
        addRow("lw 108 stall", memPkg::OpLoad, memPkg::F3Word, 12'h108, '0, 32'hf00dc3b2, 1'b1);
        addRow("sb 10c stall", memPkg::OpStore, memPkg::F3Byte, 12'h10c, 32'h0000005a, '0, 1'b1);
        addRow("lbu 10c stall", memPkg::OpLoad, memPkg::F3ByteU, 12'h10c, '0, 32'h0000005a, 1'b1);
        addRow("sw 10d stall", memPkg::OpStore, memPkg::F3Word, 12'h10d, 32'h01234567, '0, 1'b1);
        addRow("lw 10d stall", memPkg::OpLoad, memPkg::F3Word, 12'h10d, '0, 32'h01234567, 1'b1);

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        foreach (stimRows[i]) begin
            runAccess(stimRows[i].name, stimRows[i].op, stimRows[i].f3, stimRows[i].addr,
                stimRows[i].wdata, stimRows[i].stall, rdata);
            if (stimRows[i].op == memPkg::OpLoad) begin
                checkWord(stimRows[i].name, stimRows[i].expData, rdata);
            end
        end

        // program words for the fetch stream
        for (int i = 0; i < 12; i++) begin
            runAccess("program word", memPkg::OpStore, memPkg::F3Word,
                (i < 8) ? 12'h400 + AddrW'(4 * i) : 12'h600 + AddrW'(4 * (i - 8)),
                lcgNext(), 1'b0, rdata);
        end

        redirect(12'h400);
        runStream("stream", 12'h400, 8, 1'b0);
        redirect(12'h400);
        runStream("backpressure", 12'h400, 8, 1'b1);

        // loads compete with the running fetch stream
        @(posedge clk);
        instReady <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            pick = lcgNext();
            runAccess("load while fetching", memPkg::OpLoad, memPkg::funct3_t'(pick[18:16]),
                12'h100 + AddrW'(pick % 9), '0, 1'b0, rdata);
            checkWord("load while fetching", modelLoad(memPkg::funct3_t'(pick[18:16]),
                12'h100 + AddrW'(pick % 9)), rdata);
        end
        redirect(12'h600);
        runStream("redirect", 12'h600, 4, 1'b0);

        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d stalled done",
            mismatchCount, timeoutCount, stallDoneCount);
        if (mismatchCount + timeoutCount + stallDoneCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
